// ==== fabric_macros.svh ====
// Shared sizing for the register fabric.
// Included by the package and by every stage that needs a depth or a constant.

`ifndef FABRIC_MACROS_SVH
`define FABRIC_MACROS_SVH

// Bus widths
`define FABRIC_ADDR_W          12
`define FABRIC_DATA_W          32

// Address map, region number sits above this bit (256 byte regions)
`define FABRIC_REGION_SHIFT    8
`define FABRIC_NUM_REGIONS     4     // Regions 4..15 are unmapped

// Storage depths
`define FABRIC_MEM_WORDS       8     // Scratch and code window
`define FABRIC_KEY_WORDS       4     // Secret words

// Request credits held by the requester after reset
`define FABRIC_CREDITS         4

// Secret word n reads back as base + n while debug is unlocked
`define FABRIC_DEBUG_KEY_BASE  32'hDEB0_0000

`endif

// ==== fabric_pkg.sv ====
// Types shared by all fabric stages and by the testbench.
// Pull in with a wildcard import in the module or interface header.

`include "fabric_macros.svh"

package fabric_pkg;

    // Plain vectors with a meaning
    typedef logic [`FABRIC_ADDR_W-1:0]                     addr_t;
    typedef logic [`FABRIC_DATA_W-1:0]                     data_t;
    typedef logic [2:0]                                    word_off_t;   // Address bits 4:2
    typedef logic [`FABRIC_ADDR_W-`FABRIC_REGION_SHIFT-1:0] region_num_t; // Raw region number
    typedef logic [2*`FABRIC_NUM_REGIONS-1:0]              intr_vec_t;   // 2i error, 2i+1 notif

    // Mapped responder regions
    typedef enum logic [1:0] {
        REGION_SCRATCH = 2'd0,
        REGION_CTRL    = 2'd1,
        REGION_CODE    = 2'd2,
        REGION_SECRET  = 2'd3
    } region_t;

    // Control region word offsets
    localparam word_off_t CTRL_OFF_LOCK = 3'd0;  // Sticky lock bit
    localparam word_off_t CTRL_OFF_PEND = 3'd1;  // Pending interrupts, write one to clear

endpackage

// ==== fabric_if.sv ====
// Stage-to-stage links inside the fabric.
// fabric_req_if carries decoded requests into execute, fabric_rsp_if carries
// execute results into the result stage. Both are single-cycle valid, no stall.

`timescale 1ns/100ps

//==========================================================================
// Decoded request, decode -> execute
//==========================================================================
interface fabric_req_if import fabric_pkg::*; ();

    logic       valid;
    logic       write;
    logic       mapped;   // Region number below the region count
    region_t    region;
    word_off_t  offset;
    data_t      wdata;

    modport src (output valid, write, mapped, region, offset, wdata);
    modport dst (input  valid, write, mapped, region, offset, wdata);

endinterface

//==========================================================================
// Response, execute -> result
//==========================================================================
interface fabric_rsp_if import fabric_pkg::*; ();

    logic       valid;
    logic       write;
    logic       mapped;
    region_t    region;
    word_off_t  offset;   // Needed for the pending clear
    data_t      rdata;    // Write data on writes
    logic       err;

    modport src (output valid, write, mapped, region, offset, rdata, err);
    modport dst (input  valid, write, mapped, region, offset, rdata, err);

endinterface

// ==== fabric_decode.sv ====
// First fabric stage. Registers each accepted request and splits the byte
// address into a region number and a word offset for the execute stage.

`timescale 1ns/100ps

`include "fabric_macros.svh"

module fabric_decode import fabric_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,

    input  logic        req_valid_i,
    input  logic        req_write_i,
    input  addr_t       req_addr_i,
    input  data_t       req_wdata_i,

    fabric_req_if.src   req
);

    region_num_t region_num;

    // Upper address bits select the region
    always_comb begin
        region_num = req_addr_i[`FABRIC_ADDR_W-1:`FABRIC_REGION_SHIFT];
    end

    //======================================================================
    // Request register
    //======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req.valid <= 1'b0;
        end
        else begin
            req.valid <= req_valid_i;
        end
    end

    // Payload, only meaningful with valid
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            req.write  <= req_write_i;
            req.mapped <= (region_num < `FABRIC_NUM_REGIONS);
            req.region <= region_t'(region_num[$bits(region_t)-1:0]);
            req.offset <= req_addr_i[2 +: $bits(word_off_t)];  // Word, not byte
            req.wdata  <= req_wdata_i;
        end
    end

endmodule

// ==== fabric_execute.sv ====
// Second fabric stage. Holds the storage of all four regions and the sticky
// lock, decides whether a code-window access is blocked and builds the
// response. Writes return their own data in rdata so the result stage can
// use it as the pending-clear mask.

`timescale 1ns/100ps

`include "fabric_macros.svh"

module fabric_execute import fabric_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,

    input  logic        debug_locked_i,
    input  intr_vec_t   intr_pend_i,   // Pending vector from the result stage

    fabric_req_if.dst   req,
    fabric_rsp_if.src   rsp
);

    localparam int KEY_IDX_W = $clog2(`FABRIC_KEY_WORDS);

    data_t                 scratch_mem [`FABRIC_MEM_WORDS];
    data_t                 code_mem    [`FABRIC_MEM_WORDS];
    data_t                 key_mem     [`FABRIC_KEY_WORDS];
    logic                  lock_q;

    logic                  code_blocked;
    logic                  key_hit;
    logic [KEY_IDX_W-1:0]  key_idx;
    data_t                 rdata_d;
    logic                  err_d;

    //======================================================================
    // Access decision and read mux
    //======================================================================
    always_comb begin
        code_blocked = req.mapped && (req.region == REGION_CODE) && lock_q;
        key_hit      = (req.offset < `FABRIC_KEY_WORDS);
        key_idx      = req.offset[KEY_IDX_W-1:0];
        rdata_d      = '0;
        err_d        = 1'b0;

        if (!req.mapped || code_blocked) begin
            err_d = 1'b1;               // rdata stays 0
        end
        else if (req.write) begin
            rdata_d = req.wdata;        // Echo for the clear mask
        end
        else begin
            case (req.region)
                REGION_SCRATCH: rdata_d = scratch_mem[req.offset];
                REGION_CTRL: begin
                    if (req.offset == CTRL_OFF_LOCK) begin
                        rdata_d = data_t'(lock_q);
                    end
                    else if (req.offset == CTRL_OFF_PEND) begin
                        // Vector as of the previous cycle
                        rdata_d = data_t'(intr_pend_i);
                    end
                end
                REGION_CODE:    rdata_d = code_mem[req.offset];
                REGION_SECRET: begin
                    if (key_hit) begin
                        // Fixed debug values replace the keys when unlocked
                        rdata_d = debug_locked_i ? key_mem[key_idx]
                                                 : `FABRIC_DEBUG_KEY_BASE + data_t'(req.offset);
                    end
                end
                default:        rdata_d = '0;
            endcase
        end
    end

    //======================================================================
    // Region storage and lock
    //======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
            for (int i = 0; i < `FABRIC_MEM_WORDS; i++) begin
                scratch_mem[i] <= '0;
                code_mem[i]    <= '0;
            end
            for (int k = 0; k < `FABRIC_KEY_WORDS; k++) begin
                key_mem[k] <= '0;
            end
        end
        else if (req.valid && req.write && req.mapped && !code_blocked) begin
            case (req.region)
                REGION_SCRATCH: scratch_mem[req.offset] <= req.wdata;
                REGION_CTRL: begin
                    // Lock only sets, cleared by reset alone
                    if (req.offset == CTRL_OFF_LOCK && req.wdata[0]) begin
                        lock_q <= 1'b1;
                    end
                end
                REGION_CODE:    code_mem[req.offset] <= req.wdata;
                REGION_SECRET: begin
                    if (key_hit) begin
                        key_mem[key_idx] <= req.wdata;
                    end
                end
                default: ;
            endcase
        end
    end

    //======================================================================
    // Response register
    //======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp.valid <= 1'b0;
        end
        else begin
            rsp.valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp.write  <= req.write;
            rsp.mapped <= req.mapped;
            rsp.region <= req.region;
            rsp.offset <= req.offset;
            rsp.rdata  <= rdata_d;
            rsp.err    <= err_d;
        end
    end

endmodule

// ==== fabric_result.sv ====
// Last fabric stage. Drives the response outputs, returns one request credit
// per response and keeps the sticky pending interrupt vector.
// Bit 2i is the error interrupt of region i, bit 2i+1 its notification.

`timescale 1ns/100ps

module fabric_result import fabric_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,

    fabric_rsp_if.dst   rsp,

    output logic        rsp_valid_o,
    output data_t       rsp_rdata_o,
    output logic        rsp_err_o,
    output logic        req_credit_o,
    output intr_vec_t   intr_o
);

    intr_vec_t set_vec;
    intr_vec_t clr_vec;
    intr_vec_t intr_next;

    //======================================================================
    // Pending interrupt update
    //======================================================================
    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        // Unmapped accesses raise nothing
        if (rsp.valid && rsp.mapped) begin
            if (rsp.err) begin
                set_vec[{rsp.region, 1'b0}] = 1'b1;          // Error bit
            end
            else if (rsp.write) begin
                if (rsp.region == REGION_CTRL && rsp.offset == CTRL_OFF_PEND) begin
                    clr_vec = intr_vec_t'(rsp.rdata);        // Mask rides in rdata
                end
                else begin
                    set_vec[{rsp.region, 1'b1}] = 1'b1;      // Notification bit
                end
            end
        end
        // Set wins over clear
        intr_next = (intr_o & ~clr_vec) | set_vec;
    end

    //======================================================================
    // Output registers
    //======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_valid_o  <= 1'b0;
            req_credit_o <= 1'b0;
            intr_o       <= '0;
        end
        else begin
            rsp_valid_o  <= rsp.valid;
            req_credit_o <= rsp.valid;   // One credit back per response
            intr_o       <= intr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.valid) begin
            rsp_rdata_o <= rsp.rdata;
            rsp_err_o   <= rsp.err;
        end
    end

endmodule

// ==== fabric_top.sv ====
// Register fabric top level. Single-word read/write requests under credit
// flow control, answered exactly three cycles after they are accepted.
// Four regions: scratch, control (lock and pending interrupts), code window
// and secret keys. intr_o holds the sticky pending vector.

`timescale 1ns/100ps

module fabric_top import fabric_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,

    // Requester side, credit based
    input  logic        req_valid_i,
    input  logic        req_write_i,
    input  addr_t       req_addr_i,
    input  data_t       req_wdata_i,
    output logic        req_credit_o,

    // Response, never stalled
    output logic        rsp_valid_o,
    output data_t       rsp_rdata_o,
    output logic        rsp_err_o,

    input  logic        debug_locked_i,
    output intr_vec_t   intr_o
);

    //======================================================================
    // Stage links
    //======================================================================
    fabric_req_if req_link ();
    fabric_rsp_if rsp_link ();

    //======================================================================
    // Pipeline stages
    //======================================================================
    fabric_decode u_decode (
        .clk         ( clk          ),
        .rst_n_i     ( rst_n_i      ),
        .req_valid_i ( req_valid_i  ),
        .req_write_i ( req_write_i  ),
        .req_addr_i  ( req_addr_i   ),
        .req_wdata_i ( req_wdata_i  ),
        .req         ( req_link.src )
    );

    fabric_execute u_execute (
        .clk            ( clk            ),
        .rst_n_i        ( rst_n_i        ),
        .debug_locked_i ( debug_locked_i ),
        .intr_pend_i    ( intr_o         ),   // Feedback for control reads
        .req            ( req_link.dst   ),
        .rsp            ( rsp_link.src   )
    );

    fabric_result u_result (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .rsp          ( rsp_link.dst ),
        .rsp_valid_o  ( rsp_valid_o  ),
        .rsp_rdata_o  ( rsp_rdata_o  ),
        .rsp_err_o    ( rsp_err_o    ),
        .req_credit_o ( req_credit_o ),
        .intr_o       ( intr_o       )
    );

endmodule

// ==== tb_fabric_top.sv ====
// Self-checking testbench for the register fabric.
// Runs a table of reads and writes through fabric_top under credit flow control
// and checks every response three cycles after issue against a small model.

`timescale 1ns/100ps

`include "fabric_macros.svh"

module tb_fabric_top import fabric_pkg::*; ();

    localparam int NUM_ROWS   = 24;
    localparam int ROW_CYCLES = 4;      // Issue plus three cycles of latency
    localparam int LIMIT      = 2 * (NUM_ROWS * ROW_CYCLES + 12);

    typedef struct packed {
        addr_t     addr;
        logic      wr;
        data_t     data;
        logic      dbg;
        data_t     rdata;
        logic      err;
        intr_vec_t intr;
        logic      fill;    // Random write data, rdata from the model
        logic      burst;   // Issue without waiting for the previous response
    } row_t;

    logic      clk = 1'b0;
    logic      rst_n_i;
    logic      req_valid_i;
    logic      req_write_i;
    addr_t     req_addr_i;
    data_t     req_wdata_i;
    logic      debug_locked_i;
    logic      req_credit_o;
    logic      rsp_valid_o;
    data_t     rsp_rdata_o;
    logic      rsp_err_o;
    intr_vec_t intr_o;

    row_t  rows      [NUM_ROWS];
    data_t drv_data  [NUM_ROWS];
    data_t exp_rdata [NUM_ROWS];
    int    row_q     [$];           // Rows in flight, oldest first
    int    issue_q   [$];           // Matching issue cycles
    int    cycle = 0;
    int    used = 0;
    int    returned = 0;
    int    credits_min = `FABRIC_CREDITS;
    int    passed = 0;
    int    failed = 0;
    int    other_errors = 0;
    int    end_errors = 0;

    always #50 clk = ~clk;

    fabric_top uut (
        .clk            ( clk            ),
        .rst_n_i        ( rst_n_i        ),
        .req_valid_i    ( req_valid_i    ),
        .req_write_i    ( req_write_i    ),
        .req_addr_i     ( req_addr_i     ),
        .req_wdata_i    ( req_wdata_i    ),
        .req_credit_o   ( req_credit_o   ),
        .rsp_valid_o    ( rsp_valid_o    ),
        .rsp_rdata_o    ( rsp_rdata_o    ),
        .rsp_err_o      ( rsp_err_o      ),
        .debug_locked_i ( debug_locked_i ),
        .intr_o         ( intr_o         )
    );

    function automatic row_t make_row(addr_t a, logic w, data_t d, logic dbg, data_t rd,
                                      logic e, intr_vec_t iv, logic f, logic b);
        return {a, w, d, dbg, rd, e, iv, f, b};
    endfunction

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int credits_held();
        return `FABRIC_CREDITS - used + returned;
    endfunction

    //==========================================================================
    // Reference model, fills random data and data-dependent read values
    //==========================================================================
    task automatic build_expected();
        logic [15:0] lfsr;
        data_t       m_scr  [`FABRIC_MEM_WORDS];
        data_t       m_code [`FABRIC_MEM_WORDS];
        data_t       m_key  [`FABRIC_KEY_WORDS];
        logic        m_lock;
        logic [3:0]  rg;
        logic [2:0]  off;
        logic        blocked;
        data_t       d;
        lfsr   = 16'd48587;
        m_lock = 1'b0;
        for (int i = 0; i < `FABRIC_MEM_WORDS; i++) begin
            m_scr[i]  = '0;
            m_code[i] = '0;
        end
        for (int k = 0; k < `FABRIC_KEY_WORDS; k++) m_key[k] = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            rg      = rows[r].addr[`FABRIC_ADDR_W-1:`FABRIC_REGION_SHIFT];
            off     = rows[r].addr[4:2];
            blocked = (rg >= `FABRIC_NUM_REGIONS) || (rg == 4'd2 && m_lock);
            d       = rows[r].data;
            if (rows[r].fill && rows[r].wr) begin
                for (int b = 0; b < 32; b++) begin
                    lfsr = lfsr_step(lfsr);
                    d[b] = lfsr[0];    // One step per bit
                end
            end
            drv_data[r]  = d;
            exp_rdata[r] = rows[r].rdata;
            if (rows[r].fill) begin
                exp_rdata[r] = '0;
                if (!blocked && rows[r].wr) exp_rdata[r] = d;
                else if (!blocked && rg == 4'd0) exp_rdata[r] = m_scr[off];
                else if (!blocked && rg == 4'd2) exp_rdata[r] = m_code[off];
                else if (!blocked && rg == 4'd3 && off < `FABRIC_KEY_WORDS)
                    exp_rdata[r] = rows[r].dbg ? m_key[off[1:0]]
                                               : `FABRIC_DEBUG_KEY_BASE + data_t'(off);
            end
            if (rows[r].wr && !blocked) begin
                if (rg == 4'd0) m_scr[off] = d;
                if (rg == 4'd1 && off == 3'd0 && d[0]) m_lock = 1'b1;
                if (rg == 4'd2) m_code[off] = d;
                if (rg == 4'd3 && off < `FABRIC_KEY_WORDS) m_key[off[1:0]] = d;
            end
        end
    endtask

    task automatic report_row(int r, logic bad);
        $display("Row %2d addr %h %s : %s", r, rows[r].addr,
                 rows[r].wr ? "write" : "read ", bad ? "FAILED" : "ok");
        if (bad) failed++;
        else passed++;
    endtask

    //==========================================================================
    // Cycle count and run limit
    //==========================================================================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Responses and credits, sampled mid-cycle
    always @(negedge clk) begin : check_responses
        int   r;
        int   issued;
        logic bad;
        if (rst_n_i) begin
            if (req_credit_o === 1'b1) returned++;
            assert (req_credit_o === rsp_valid_o) else begin
                $display("Credit pulse and response disagree at %0t", $time);
                other_errors++;
            end
            if (rsp_valid_o === 1'b1 && row_q.size() == 0) begin
                $display("Response at %0t with no request outstanding", $time);
                other_errors++;
            end
            else if (rsp_valid_o === 1'b1) begin
                r      = row_q.pop_front();
                issued = issue_q.pop_front();
                bad    = 1'b0;
                assert (cycle == issued + 3) else begin
                    $display("Row %0d answered at cycle %0d instead of %0d", r, cycle, issued + 3);
                    bad = 1'b1;
                end
                assert (rsp_rdata_o === exp_rdata[r]) else begin
                    $display("Mismatch at %0t: row %0d rdata %h, expected %h",
                             $time, r, rsp_rdata_o, exp_rdata[r]);
                    bad = 1'b1;
                end
                assert (rsp_err_o === rows[r].err) else begin
                    $display("Mismatch at %0t: row %0d err %b, expected %b",
                             $time, r, rsp_err_o, rows[r].err);
                    bad = 1'b1;
                end
                assert (intr_o === rows[r].intr) else begin
                    $display("Mismatch at %0t: row %0d intr_o %h, expected %h",
                             $time, r, intr_o, rows[r].intr);
                    bad = 1'b1;
                end
                report_row(r, bad);
            end
            else if (row_q.size() != 0 && cycle > issue_q[0] + 3) begin
                r = row_q.pop_front();
                issue_q.delete(0);
                $display("No response for row %0d by %0t", r, $time);
                report_row(r, 1'b1);
            end
        end
    end

    //==========================================================================
    // Stimulus table and driver
    //==========================================================================
    initial begin
        rst_n_i        = 1'b0;
        req_valid_i    = 1'b0;
        req_write_i    = 1'b0;
        req_addr_i     = '0;
        req_wdata_i    = '0;
        debug_locked_i = 1'b1;

        // addr, write, data, debug_locked, rdata, err, intr_o, fill, burst
        rows[0]  = make_row(12'h008, 1'b1, 32'h0,  1'b1, 32'h0,  1'b0, 8'h02, 1'b1, 1'b0);
        rows[1]  = make_row(12'h214, 1'b1, 32'h0,  1'b1, 32'h0,  1'b0, 8'h22, 1'b1, 1'b0);
        rows[2]  = make_row(12'h008, 1'b0, 32'h0,  1'b1, 32'h0,  1'b0, 8'h22, 1'b1, 1'b0);
        rows[3]  = make_row(12'h214, 1'b0, 32'h0,  1'b1, 32'h0,  1'b0, 8'h22, 1'b1, 1'b0);
        rows[4]  = make_row(12'h5A0, 1'b0, 32'h0,  1'b1, 32'h0,  1'b1, 8'h22, 1'b0, 1'b0);
        rows[5]  = make_row(12'hF04, 1'b1, 32'h1234, 1'b1, 32'h0, 1'b1, 8'h22, 1'b0, 1'b0);
        rows[6]  = make_row(12'h304, 1'b1, 32'h0,  1'b1, 32'h0,  1'b0, 8'hA2, 1'b1, 1'b0);
        rows[7]  = make_row(12'h304, 1'b0, 32'h0,  1'b1, 32'h0,  1'b0, 8'hA2, 1'b1, 1'b0);
        rows[8]  = make_row(12'h304, 1'b0, 32'h0,  1'b0, `FABRIC_DEBUG_KEY_BASE + 32'd1,
                            1'b0, 8'hA2, 1'b0, 1'b0);
        rows[9]  = make_row(12'h30C, 1'b0, 32'h0,  1'b0, `FABRIC_DEBUG_KEY_BASE + 32'd3,
                            1'b0, 8'hA2, 1'b0, 1'b0);
        rows[10] = make_row(12'h314, 1'b0, 32'h0,  1'b1, 32'h0,  1'b0, 8'hA2, 1'b0, 1'b0);
        rows[11] = make_row(12'h104, 1'b1, 32'h22, 1'b1, 32'h22, 1'b0, 8'h80, 1'b0, 1'b0);
        rows[12] = make_row(12'h104, 1'b0, 32'h0,  1'b1, 32'h80, 1'b0, 8'h80, 1'b0, 1'b0);
        rows[13] = make_row(12'h100, 1'b1, 32'h1,  1'b1, 32'h1,  1'b0, 8'h88, 1'b0, 1'b0);
        rows[14] = make_row(12'h100, 1'b0, 32'h0,  1'b1, 32'h1,  1'b0, 8'h88, 1'b0, 1'b0);
        rows[15] = make_row(12'h214, 1'b1, 32'h0,  1'b1, 32'h0,  1'b1, 8'h98, 1'b1, 1'b0);
        rows[16] = make_row(12'h214, 1'b0, 32'h0,  1'b1, 32'h0,  1'b1, 8'h98, 1'b0, 1'b0);
        rows[17] = make_row(12'h01C, 1'b1, 32'h0,  1'b1, 32'h0,  1'b0, 8'h9A, 1'b1, 1'b0);
        rows[18] = make_row(12'h01C, 1'b0, 32'h0,  1'b1, 32'h0,  1'b0, 8'h9A, 1'b1, 1'b0);
        rows[19] = make_row(12'h000, 1'b1, 32'h0,  1'b1, 32'h0,  1'b0, 8'h9A, 1'b1, 1'b0);
        rows[20] = make_row(12'h004, 1'b1, 32'h0,  1'b1, 32'h0,  1'b0, 8'h9A, 1'b1, 1'b1);
        rows[21] = make_row(12'h000, 1'b0, 32'h0,  1'b1, 32'h0,  1'b0, 8'h9A, 1'b1, 1'b1);
        rows[22] = make_row(12'h004, 1'b0, 32'h0,  1'b1, 32'h0,  1'b0, 8'h9A, 1'b1, 1'b1);
        rows[23] = make_row(12'h104, 1'b0, 32'h0,  1'b1, 32'h9A, 1'b0, 8'h9A, 1'b0, 1'b0);
        build_expected();

        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            req_valid_i <= 1'b0;
            // Needs a credit, and single rows wait for the pipe to drain
            while (credits_held() == 0 || (!rows[r].burst && row_q.size() != 0))
                @(posedge clk);
            req_valid_i    <= 1'b1;
            req_write_i    <= rows[r].wr;
            req_addr_i     <= rows[r].addr;
            req_wdata_i    <= drv_data[r];
            debug_locked_i <= rows[r].dbg;
            row_q.push_back(r);
            issue_q.push_back(cycle + 1);
            used++;
            if (credits_held() < credits_min) credits_min = credits_held();
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        while (row_q.size() != 0) @(posedge clk);

        assert (credits_held() == `FABRIC_CREDITS) else begin
            $display("Credits did not return, holding %0d of %0d",
                     credits_held(), `FABRIC_CREDITS);
            end_errors++;
        end
        assert (credits_min == 0) else begin
            $display("Back to back requests never used up all credits");
            end_errors++;
        end

        $display("Rows passed %0d, rows failed %0d, other errors %0d",
                 passed, failed, other_errors + end_errors);
        if (failed == 0 && other_errors == 0 && end_errors == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
fabric_pkg.sv
fabric_if.sv
fabric_decode.sv
fabric_execute.sv
fabric_result.sv
fabric_top.sv
tb_fabric_top.sv

// ==== Bender.yml ====
package:
  name: fabric_top

sources:
  - include_dirs:
      - .
    files:
      - fabric_pkg.sv
      - fabric_if.sv
      - fabric_decode.sv
      - fabric_execute.sv
      - fabric_result.sv
      - fabric_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fabric_top.sv
